// ==== src/apbPkg.sv ====
// APB bus definitions for the word game register block.
// Request and response bundles plus the register map.

package apbPkg;

    // --------------------
    // Bus bundles
    // --------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbReq;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp;

    // --------------------
    // Register map
    // --------------------
    typedef enum logic [7:0] {
        WORD_LO = 8'h00, // Letters 0 to 3, letter 0 on top.
        WORD_HI = 8'h04, // Letters 4 to 7.
        CTRL    = 8'h08, // Start and end pulses.
        STATUS  = 8'h0C  // Read only.
    } regAddr;

endpackage

// ==== src/gamePkg.sv ====
// Word game types shared by the registers and the guess pipeline.
// Letters, the game phase and the stage-to-stage bundles.

package gamePkg;

    typedef logic [7:0] letter;

    localparam int maxLetters = 8;

    typedef enum logic [1:0] {
        SETUP = 2'd0,
        PLAY  = 2'd1,
        WON   = 2'd2,
        LOST  = 2'd3
    } gamePhase;

    // Position 0 sits in the top byte.
    typedef letter [0:maxLetters-1] secretWord;

    // --------------------
    // Pipeline bundles
    // --------------------
    typedef struct packed {
        logic  valid;
        letter guess;
    } guessItem;

    typedef struct packed {
        logic                  valid;
        logic [3:0]            hits;  // Newly revealed positions.
        logic [maxLetters-1:0] mask;
    } matchResult;

    typedef struct packed {
        logic start;
        logic stop;
    } gameCtrl;

    typedef struct packed {
        gamePhase              phase;
        logic [3:0]            correct;
        logic [2:0]            mistakes;
        logic [maxLetters-1:0] mask;
    } gameStatus;

endpackage

// ==== src/apbWordRegs.sv ====
// APB slave for the word game.
// Holds the secret word, issues start and end pulses, reports status.

module apbWordRegs (
    input  logic                clk,
    input  logic                nRst,
    input  apbPkg::apbReq       apbIn,
    output apbPkg::apbRsp       apbOut,
    input  gamePkg::gameStatus  status,
    output gamePkg::secretWord  word,
    output gamePkg::gameCtrl    ctrl
);
    import apbPkg::*;

    logic        setup;
    logic        access;
    logic        wrEn;
    logic        addrOk;
    logic [31:0] wordLo;
    logic [31:0] wordHi;
    logic [31:0] rdData;

    assign setup  = apbIn.psel && !apbIn.penable;
    assign access = apbIn.psel && apbIn.penable;
    assign wrEn   = access && apbIn.pwrite && addrOk;

    // --------------------
    // Address decode
    // --------------------
    always_comb begin
        addrOk = 1'b1;
        rdData = '0;
        case (apbIn.paddr)
            WORD_LO: rdData = wordLo;
            WORD_HI: rdData = wordHi;
            CTRL:    rdData = '0; // Pulses only.
            STATUS:  rdData = {8'h00, status.mask, 7'h00, status.mistakes,
                               status.correct, status.phase};
            default: addrOk = 1'b0;
        endcase
    end

    assign apbOut = '{prdata:  (access && !apbIn.pwrite) ? rdData : 32'h0,
                      pready:  1'b1,
                      pslverr: access && !addrOk};

    // --------------------
    // Host registers
    // --------------------
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            wordLo <= '0;
            wordHi <= '0;
            ctrl   <= '0;
        end else begin
            ctrl <= '0;
            if (wrEn) begin
                case (apbIn.paddr)
                    WORD_LO: wordLo <= apbIn.pwdata;
                    WORD_HI: wordHi <= apbIn.pwdata;
                    CTRL:    ctrl <= '{start: apbIn.pwdata[0], stop: apbIn.pwdata[1]};
                    default: ;
                endcase
            end
        end
    end

    // Game word is frozen for the whole game.
    always_ff @(posedge clk) begin
        if (ctrl.start) begin
            word <= {wordLo, wordHi};
        end
    end

    // Error only in an access cycle that followed its setup cycle.
    errInAccess: assert property (@(posedge clk) disable iff (!nRst)
        apbOut.pslverr |-> access && $past(setup));

endmodule

// ==== src/guessCapture.sv ====
// Guess capture stage.
// One-deep buffer for player letters, open only while a game is in play.

module guessCapture (
    input  logic               clk,
    input  logic               nRst,
    input  logic               guessValid,
    input  gamePkg::letter     guessLetter,
    output logic               guessReady,
    input  gamePkg::gamePhase  phase,
    input  logic               stop,
    input  logic               matchBusy,
    output gamePkg::guessItem  item
);
    import gamePkg::*;

    logic  bufValid;
    letter bufLetter;
    logic  take;
    logic  accept;

    assign item       = '{valid: bufValid && (phase == PLAY), guess: bufLetter};
    assign take       = item.valid && !matchBusy;
    assign guessReady = (phase == PLAY) && !stop && (!bufValid || take);
    assign accept     = guessValid && guessReady;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            bufValid <= 1'b0;
        end else if (stop) begin
            bufValid <= 1'b0; // Flush.
        end else if (accept) begin
            bufValid <= 1'b1;
        end else if (take) begin
            bufValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bufLetter <= guessLetter;
        end
    end

    // A waiting guess is held until the match stage takes it.
    holdWhileWaiting: assert property (@(posedge clk) disable iff (!nRst)
        (bufValid && !take && !stop) |=> (bufValid && $stable(bufLetter)));

endmodule

// ==== src/letterMatch.sv ====
// Letter match stage.
// Compares the held guess against one word position per clock and
// keeps the mask of revealed positions for the running game.

module letterMatch #(
    parameter int wordLen = 5
) (
    input  logic                clk,
    input  logic                nRst,
    input  gamePkg::guessItem   item,
    input  gamePkg::secretWord  word,
    input  gamePkg::gameCtrl    ctrl,
    output logic                matchBusy,
    output gamePkg::letter      letterOut,
    output gamePkg::matchResult result
);
    import gamePkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DONE
    } scanState;

    localparam int posBits = $clog2(maxLetters);
    localparam logic [posBits-1:0] lastPos = posBits'(wordLen - 1);

    scanState              state;
    logic [posBits-1:0]    pos;
    letter                 heldLetter;
    logic [maxLetters-1:0] mask;
    logic [3:0]            hitCount;
    logic                  resultValid;
    logic                  hit;

    // Already revealed positions do not count again.
    assign hit = (state == SCAN) && (word[pos] == heldLetter) && !mask[pos];

    assign matchBusy = (state != IDLE);
    assign letterOut = heldLetter;
    assign result    = '{valid: resultValid, hits: hitCount, mask: mask};

    // --------------------
    // Scan control
    // --------------------
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state       <= IDLE;
            pos         <= '0;
            hitCount    <= '0;
            resultValid <= 1'b0;
            heldLetter  <= '0;
        end else begin
            resultValid <= 1'b0;
            if (ctrl.start || ctrl.stop) begin
                state <= IDLE; // Abandon any scan.
            end else begin
                case (state)
                    IDLE: begin
                        if (item.valid) begin
                            heldLetter <= item.guess;
                            pos        <= '0;
                            hitCount   <= '0;
                            state      <= SCAN;
                        end
                    end
                    SCAN: begin
                        if (hit) begin
                            hitCount <= hitCount + 4'd1;
                        end
                        if (pos == lastPos) begin
                            state <= DONE;
                        end else begin
                            pos <= pos + 1'b1;
                        end
                    end
                    DONE: begin
                        resultValid <= 1'b1; // Hits are final here.
                        state       <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // --------------------
    // Revealed mask
    // --------------------
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            mask <= '0;
        end else if (ctrl.start) begin
            mask <= '0;
        end else if (hit && !ctrl.stop) begin
            mask[pos] <= 1'b1;
        end
    end

    // Revealed positions stay revealed until a new game.
    maskSticky: assert property (@(posedge clk) disable iff (!nRst)
        ((mask & $past(mask)) != $past(mask)) |-> $past(ctrl.start));

endmodule

// ==== src/scoreKeeper.sv ====
// Score stage.
// Counts correct letters and mistakes, runs the game phase and the lamps.

module scoreKeeper #(
    parameter int wordLen     = 5,
    parameter int maxMistakes = 6
) (
    input  logic                clk,
    input  logic                nRst,
    input  gamePkg::matchResult result,
    input  gamePkg::gameCtrl    ctrl,
    output gamePkg::gamePhase   phase,
    output logic [3:0]          correct,
    output logic [2:0]          mistakes,
    output logic                mistake,
    output logic                green,
    output logic                red
);
    import gamePkg::*;

    logic [3:0] correctNext;
    logic [2:0] mistakesNext;

    assign correctNext  = correct + result.hits;
    assign mistakesNext = mistakes + 3'd1;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            phase    <= SETUP;
            correct  <= '0;
            mistakes <= '0;
            mistake  <= 1'b0;
        end else begin
            mistake <= 1'b0;
            if (ctrl.stop) begin
                phase <= SETUP;
            end else if (ctrl.start) begin
                phase    <= PLAY;
                correct  <= '0;
                mistakes <= '0;
            end else if (result.valid && (phase == PLAY)) begin
                if (result.hits != 4'd0) begin
                    correct <= correctNext;
                    if (correctNext >= 4'(wordLen)) begin
                        phase <= WON;
                    end
                end else begin
                    mistakes <= mistakesNext;
                    mistake  <= 1'b1;
                    if (mistakesNext >= 3'(maxMistakes)) begin
                        phase <= LOST;
                    end
                end
            end
        end
    end

    assign green = (phase == WON);
    assign red   = (phase == LOST);

    // Hits come from the match stage, which never counts a position twice.
    correctBound: assert property (@(posedge clk) disable iff (!nRst)
        correct <= 4'(wordLen));
    mistakeBound: assert property (@(posedge clk) disable iff (!nRst)
        mistakes <= 3'(maxMistakes));

endmodule

// ==== src/wordGame.sv ====
// Word game top level.
// APB register block feeding the capture, match and score stages.

module wordGame #(
    parameter int wordLen     = 5,
    parameter int maxMistakes = 6
) (
    input  logic                             clk,
    input  logic                             nRst,
    input  apbPkg::apbReq                    apbIn,
    output apbPkg::apbRsp                    apbOut,
    input  logic                             guessValid,
    input  gamePkg::letter                   guessLetter,
    output logic                             guessReady,
    output gamePkg::letter                   letterOut,
    output logic [gamePkg::maxLetters-1:0]   revealed,
    output logic [3:0]                       correct,
    output logic [2:0]                       mistakes,
    output logic                             mistake,
    output logic                             green,
    output logic                             red
);
    import gamePkg::*;

    secretWord  word;
    gameCtrl    ctrl;
    gameStatus  status;
    gamePhase   phase;
    guessItem   item;
    matchResult result;
    logic       matchBusy;

    assign status   = '{phase: phase, correct: correct, mistakes: mistakes, mask: result.mask};
    assign revealed = result.mask;

    apbWordRegs regs0 (
        .clk(clk), .nRst(nRst),
        .apbIn(apbIn), .apbOut(apbOut),
        .status(status), .word(word), .ctrl(ctrl)
    );

    guessCapture capture0 (
        .clk(clk), .nRst(nRst),
        .guessValid(guessValid), .guessLetter(guessLetter), .guessReady(guessReady),
        .phase(phase), .stop(ctrl.stop), .matchBusy(matchBusy), .item(item)
    );

    letterMatch #(.wordLen(wordLen)) match0 (
        .clk(clk), .nRst(nRst),
        .item(item), .word(word), .ctrl(ctrl),
        .matchBusy(matchBusy), .letterOut(letterOut), .result(result)
    );

    scoreKeeper #(.wordLen(wordLen), .maxMistakes(maxMistakes)) score0 (
        .clk(clk), .nRst(nRst),
        .result(result), .ctrl(ctrl), .phase(phase),
        .correct(correct), .mistakes(mistakes), .mistake(mistake),
        .green(green), .red(red)
    );

endmodule

// ==== test/wordGameTb.sv ====
// Testbench for the word game engine.
// Drives APB and guesses; a reference model feeds the checking assertions.

module wordGameTb;
    timeunit 1ns;
    timeprecision 100ps;

    import apbPkg::*;
    import gamePkg::*;

    localparam int wordLen     = 5;
    localparam int maxMistakes = 6;
    localparam int guessLimit  = 40;
    localparam int idleLimit   = 60;

    logic                  clk;
    logic                  nRst;
    apbReq                 apbIn;
    apbRsp                 apbOut;
    logic                  guessValid;
    letter                 guessLetter;
    logic                  guessReady;
    letter                 letterOut;
    logic [maxLetters-1:0] revealed;
    logic [3:0]            correct;
    logic [2:0]            mistakes;
    logic                  mistake;
    logic                  green;
    logic                  red;

    // Reference model state.
    letter                 hostWord [0:maxLetters-1];
    letter                 gameWord [0:maxLetters-1];
    logic [maxLetters-1:0] expMask;
    logic [3:0]            expCorrect;
    logic [2:0]            expMistakes;
    logic                  expPulse;
    gamePhase              expPhase;
    logic                  startPend;
    logic                  stopPend;
    logic                  inFlight;
    logic [31:0]           expRd;
    logic                  expErr;
    letter                 pendLetter [$];
    int                    pendDue [$];
    letter                 expLetter;
    letter                 loadLetter [$];
    int                    loadDue [$];
    int                    cyc;
    int                    lastLoad;
    int                    errCount;
    logic [31:0]           lfsr;

    wordGame #(.wordLen(wordLen), .maxMistakes(maxMistakes)) dut0 (
        .clk(clk), .nRst(nRst), .apbIn(apbIn), .apbOut(apbOut),
        .guessValid(guessValid), .guessLetter(guessLetter), .guessReady(guessReady),
        .letterOut(letterOut), .revealed(revealed), .correct(correct),
        .mistakes(mistakes), .mistake(mistake), .green(green), .red(red)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // Failure reporting
    // --------------------
    task automatic stopOnError();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        errCount++;
        $display("[ERROR] %s is 0x%0h, expected 0x%0h", name, got, exp);
        stopOnError();
    endtask

    task automatic reportPlain(input string what);
        errCount++;
        $display("Error: %s", what);
        stopOnError();
    endtask

    // --------------------
    // Random letters
    // --------------------
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32,22,2,1.
    endfunction

    function automatic logic [7:0] takeBits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic inWord(input letter l);
        logic found;
        found = 1'b0;
        for (int p = 0; p < wordLen; p++) begin
            if (hostWord[p] == l) found = 1'b1;
        end
        return found;
    endfunction

    task automatic pickWrong(output letter l);
        logic [7:0] v;
        logic       found;
        int         tries;
        found = 1'b0;
        tries = 0;
        l     = 8'h41;
        while (!found) begin
            v = takeBits(5);
            tries++;
            if (v < 8'd26) begin
                l     = 8'h41 + v; // Upper case A to Z.
                found = !inWord(l);
            end
            if (!found && tries > 200) reportPlain("no random letter found outside the word");
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [31:0] statusWord();
        logic [31:0] w;
        w        = '0;
        w[1:0]   = expPhase;
        w[5:2]   = expCorrect;
        w[8:6]   = expMistakes;
        w[23:16] = expMask;
        return w;
    endfunction

    task automatic scoreGuess(input letter l);
        logic [maxLetters-1:0] m;
        logic [3:0]            hits;
        m    = expMask;
        hits = '0;
        for (int p = 0; p < wordLen; p++) begin
            if (gameWord[p] == l && !m[p]) begin
                m[p] = 1'b1;
                hits++;
            end
        end
        expMask <= m;
        if (hits != 0) begin
            expCorrect <= expCorrect + hits;
            if (expCorrect + hits >= wordLen) expPhase <= WON;
        end else begin
            expMistakes <= expMistakes + 3'd1;
            expPulse    <= 1'b1;
            if (expMistakes + 1 >= maxMistakes) expPhase <= LOST;
        end
    endtask

    always @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            expMask     <= '0;
            expCorrect  <= '0;
            expMistakes <= '0;
            expPulse    <= 1'b0;
            expPhase    <= SETUP;
            expLetter   <= '0;
            startPend   <= 1'b0;
            stopPend    <= 1'b0;
            inFlight    <= 1'b0;
            pendLetter.delete();
            pendDue.delete();
            loadLetter.delete();
            loadDue.delete();
            cyc      = 0;
            lastLoad = -100;
        end else begin
            expPulse  <= 1'b0;
            startPend <= apbIn.psel && apbIn.penable && apbIn.pwrite
                         && apbIn.paddr == CTRL && apbIn.pwdata[0];
            stopPend  <= apbIn.psel && apbIn.penable && apbIn.pwrite
                         && apbIn.paddr == CTRL && apbIn.pwdata[1];
            if (stopPend || startPend) begin
                pendLetter.delete();
                pendDue.delete();
                loadLetter.delete();
                loadDue.delete();
                lastLoad = -100;
                inFlight <= 1'b0;
                expPhase <= stopPend ? SETUP : PLAY;
                if (!stopPend) begin
                    gameWord    <= hostWord;
                    expMask     <= '0;
                    expCorrect  <= '0;
                    expMistakes <= '0;
                end
            end else begin
                if (guessValid && guessReady) begin
                    // Match stage loads once it is free, then takes wordLen+2 cycles.
                    lastLoad = (cyc + 1 > lastLoad + wordLen + 2) ? cyc + 1
                                                                   : lastLoad + wordLen + 2;
                    pendLetter.push_back(guessLetter);
                    pendDue.push_back(lastLoad + wordLen + 2);
                    loadLetter.push_back(guessLetter);
                    loadDue.push_back(lastLoad);
                end
                if (loadDue.size() != 0 && loadDue[0] == cyc) begin
                    expLetter <= loadLetter[0]; // Shown from the load edge on.
                    void'(loadLetter.pop_front());
                    void'(loadDue.pop_front());
                end
                if (pendDue.size() != 0 && pendDue[0] == cyc) begin
                    if (expPhase == PLAY) scoreGuess(pendLetter[0]);
                    void'(pendLetter.pop_front());
                    void'(pendDue.pop_front());
                end
                inFlight <= (pendDue.size() != 0);
            end
            cyc++;
        end
    end

    // --------------------
    // Checks
    // --------------------
    correctCheck: assert property (@(posedge clk) disable iff (!nRst) correct == expCorrect)
        else reportValue("correct", $sampled(correct), $sampled(expCorrect));
    mistakesCheck: assert property (@(posedge clk) disable iff (!nRst) mistakes == expMistakes)
        else reportValue("mistakes", $sampled(mistakes), $sampled(expMistakes));
    pulseCheck: assert property (@(posedge clk) disable iff (!nRst) mistake == expPulse)
        else reportValue("mistake", $sampled(mistake), $sampled(expPulse));
    greenCheck: assert property (@(posedge clk) disable iff (!nRst) green == (expPhase == WON))
        else reportValue("green", $sampled(green), $sampled(expPhase == WON));
    redCheck: assert property (@(posedge clk) disable iff (!nRst) red == (expPhase == LOST))
        else reportValue("red", $sampled(red), $sampled(expPhase == LOST));
    maskCheck: assert property (@(posedge clk) disable iff (!nRst)
        !inFlight |-> revealed == expMask)
        else reportValue("revealed", $sampled(revealed), $sampled(expMask));
    letterCheck: assert property (@(posedge clk) disable iff (!nRst) letterOut == expLetter)
        else reportValue("letterOut", $sampled(letterOut), $sampled(expLetter));
    readyCheck: assert property (@(posedge clk) disable iff (!nRst)
        guessReady |-> expPhase == PLAY)
        else reportPlain("guess port was ready while no game was in play");
    readyHighCheck: assert property (@(posedge clk) disable iff (!nRst) apbOut.pready)
        else reportPlain("APB pready dropped low");
    rdataCheck: assert property (@(posedge clk) disable iff (!nRst)
        (apbIn.psel && apbIn.penable && !apbIn.pwrite) |-> apbOut.prdata == expRd)
        else reportValue("prdata", $sampled(apbOut.prdata), $sampled(expRd));
    slverrCheck: assert property (@(posedge clk) disable iff (!nRst)
        (apbIn.psel && apbIn.penable) |-> apbOut.pslverr == expErr)
        else reportValue("pslverr", $sampled(apbOut.pslverr), $sampled(expErr));

    // --------------------
    // Drivers
    // --------------------
    task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                           input logic [31:0] rdExp, input logic errExp);
        apbIn = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        @(posedge clk);
        #5;
        apbIn.penable = 1'b1;
        expRd         = rdExp;
        expErr        = errExp;
        @(posedge clk);
        #5;
        apbIn = '0;
    endtask

    task automatic writeWord(input logic [63:0] w);
        for (int i = 0; i < maxLetters; i++) hostWord[i] = w[63-8*i -: 8];
        apbXfer(1'b1, WORD_LO, w[63:32], '0, 1'b0);
        apbXfer(1'b1, WORD_HI, w[31:0], '0, 1'b0);
        apbXfer(1'b0, WORD_LO, '0, w[63:32], 1'b0);
        apbXfer(1'b0, WORD_HI, '0, w[31:0], 1'b0);
    endtask

    task automatic writeCtrl(input logic [31:0] bits);
        apbXfer(1'b1, CTRL, bits, '0, 1'b0);
        @(posedge clk); // Phase follows the pulse.
        #5;
        apbXfer(1'b0, STATUS, '0, statusWord(), 1'b0);
    endtask

    task automatic sendGuess(input letter l);
        int n;
        n           = 0;
        guessValid  = 1'b1;
        guessLetter = l;
        do begin
            @(posedge clk);
            n++;
            if (!guessReady && n > guessLimit) reportPlain("guess was never accepted");
        end while (!guessReady);
        #5;
        guessValid = 1'b0;
    endtask

    task automatic waitIdle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (inFlight && n > idleLimit) reportPlain("guess was never scored");
        end while (inFlight);
        #5;
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        letter l;
        nRst        = 1'b0;
        apbIn       = '0;
        guessValid  = 1'b0;
        guessLetter = '0;
        expRd       = '0;
        expErr      = 1'b0;
        errCount    = 0;
        lfsr        = 32'hce0084ae;
        repeat (16) @(posedge clk);
        #5;
        nRst = 1'b1;

        writeWord(64'h4150504C_45000000); // APPLE.
        apbXfer(1'b0, 8'h10, '0, '0, 1'b1);
        apbXfer(1'b1, 8'h14, 32'h12345678, '0, 1'b1);
        writeCtrl(32'h1);

        sendGuess(8'h50); // P at two positions.
        waitIdle();
        sendGuess(8'h5A); // Z is wrong.
        waitIdle();
        sendGuess(8'h50); // Repeat of a revealed letter.
        waitIdle();

        sendGuess(8'h41); // A, L and X back to back.
        sendGuess(8'h4C);
        sendGuess(8'h58);
        waitIdle();

        sendGuess(8'h45); // Last letter wins.
        waitIdle();
        guessValid  = 1'b1;
        guessLetter = 8'h51;
        repeat (12) @(posedge clk);
        #5;
        guessValid = 1'b0;
        apbXfer(1'b0, STATUS, '0, statusWord(), 1'b0);

        writeWord(64'h4D4F5553_45000000); // MOUSE.
        writeCtrl(32'h1);
        for (int i = 0; i < maxMistakes; i++) begin
            pickWrong(l);
            sendGuess(l);
            waitIdle();
        end
        writeCtrl(32'h2);

        if (errCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stopOnError();
        end
    end

endmodule

// ==== compile.f ====
src/apbPkg.sv
src/gamePkg.sv
src/apbWordRegs.sv
src/guessCapture.sv
src/letterMatch.sv
src/scoreKeeper.sv
src/wordGame.sv
test/wordGameTb.sv
